//--- rtl/simple_system_defines.svh
// Simple system address map, RAM size and device register offsets

`ifndef SIMPLE_SYSTEM_DEFINES_SVH
`define SIMPLE_SYSTEM_DEFINES_SVH

// RAM region, 4 kB
`define RAM_BASE      32'h0010_0000
`define RAM_MASK      32'hFFFF_F000
`define RAM_WORDS     1024

// Simulation control region, 1 kB
`define SIM_CTRL_BASE 32'h0002_0000
`define SIM_CTRL_MASK 32'hFFFF_FC00
`define SIM_CTRL_OUT  32'h0000_0000
`define SIM_CTRL_HALT 32'h0000_0008

// Machine timer region, 1 kB
`define TIMER_BASE    32'h0003_0000
`define TIMER_MASK    32'hFFFF_FC00
`define MTIME_LO      32'h0000_0000
`define MTIME_HI      32'h0000_0004
`define MTIMECMP_LO   32'h0000_0008
`define MTIMECMP_HI   32'h0000_000C

`endif

//--- rtl/simple_system_pkg.sv
// Simple system bus types shared by the interconnect and its devices

`default_nettype none

package simple_system_pkg;

  // Byte address and data word of the bus
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // One enable per byte lane
  typedef logic [3:0] be_t;

  // Counter and compare width of the machine timer
  typedef logic [63:0] timer_t;

  // Request as issued by the host
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } bus_req_t;

  // Response, one cycle after the grant
  typedef struct packed {
    logic  rvalid;
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // Device that owns an access
  typedef enum logic [1:0] {
    DEV_RAM      = 2'd0,
    DEV_SIM_CTRL = 2'd1,
    DEV_TIMER    = 2'd2,
    DEV_NONE     = 2'd3
  } dev_sel_t;

endpackage

`default_nettype wire

//--- rtl/bus_xbar.sv
// Bus crossbar routing one host to the RAM, sim control and timer devices

`timescale 1ns/100ps
`default_nettype none

`include "simple_system_defines.svh"

module bus_xbar (
  input  wire                         clk_i,
  input  wire                         rst_i,

  input  simple_system_pkg::bus_req_t host_req_i,
  output logic                        host_gnt_o,
  output simple_system_pkg::bus_rsp_t host_rsp_o,

  output simple_system_pkg::bus_req_t ram_req_o,
  output simple_system_pkg::bus_req_t ctrl_req_o,
  output simple_system_pkg::bus_req_t timer_req_o,

  input  simple_system_pkg::bus_rsp_t ram_rsp_i,
  input  simple_system_pkg::bus_rsp_t ctrl_rsp_i,
  input  simple_system_pkg::bus_rsp_t timer_rsp_i
);

  simple_system_pkg::dev_sel_t dev_sel;
  simple_system_pkg::dev_sel_t sel_q;
  logic                        pend_q;

  // No back-pressure, every request is taken at once
  assign host_gnt_o = host_req_i.req;

  // Region match on base and mask
  always_comb begin
    if ((host_req_i.addr & `RAM_MASK) == `RAM_BASE) begin
      dev_sel = simple_system_pkg::DEV_RAM;
    end else if ((host_req_i.addr & `SIM_CTRL_MASK) == `SIM_CTRL_BASE) begin
      dev_sel = simple_system_pkg::DEV_SIM_CTRL;
    end else if ((host_req_i.addr & `TIMER_MASK) == `TIMER_BASE) begin
      dev_sel = simple_system_pkg::DEV_TIMER;
    end else begin
      dev_sel = simple_system_pkg::DEV_NONE;
    end
  end

  // Same payload to all devices, req only to the selected one
  always_comb begin
    ram_req_o   = host_req_i;
    ctrl_req_o  = host_req_i;
    timer_req_o = host_req_i;

    ram_req_o.req   = host_req_i.req && (dev_sel == simple_system_pkg::DEV_RAM);
    ctrl_req_o.req  = host_req_i.req && (dev_sel == simple_system_pkg::DEV_SIM_CTRL);
    timer_req_o.req = host_req_i.req && (dev_sel == simple_system_pkg::DEV_TIMER);
  end

  // Remember the owner of the access in flight
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sel_q  <= simple_system_pkg::DEV_NONE;
      pend_q <= 1'b0;
    end else begin
      sel_q  <= dev_sel;
      pend_q <= host_req_i.req;
    end
  end

  // Response mux, unmapped accesses answered here with an error
  always_comb begin
    case (sel_q)
      simple_system_pkg::DEV_RAM: begin
        host_rsp_o = ram_rsp_i;
      end
      simple_system_pkg::DEV_SIM_CTRL: begin
        host_rsp_o = ctrl_rsp_i;
      end
      simple_system_pkg::DEV_TIMER: begin
        host_rsp_o = timer_rsp_i;
      end
      default: begin
        host_rsp_o = '{rvalid: pend_q, rdata: '0, err: pend_q};
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/ram_1p.sv
// Single-port word SRAM with byte-enable writes and a registered response

`timescale 1ns/100ps
`default_nettype none

module ram_1p #(
  parameter int unsigned Depth = 1024
) (
  input  wire                         clk_i,
  input  wire                         rst_i,

  input  simple_system_pkg::bus_req_t req_i,
  output simple_system_pkg::bus_rsp_t rsp_o
);

  localparam int unsigned AddrBits = $clog2(Depth);

  simple_system_pkg::data_t mem [Depth];
  simple_system_pkg::data_t rdata_q;
  logic                     rvalid_q;
  logic [AddrBits-1:0]      word_idx;

  // Word index above the byte lane bits
  assign word_idx = req_i.addr[AddrBits+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int i = 0; i < $bits(simple_system_pkg::be_t); i++) begin
          if (req_i.be[i]) begin
            mem[word_idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
          end
        end
      end
      rdata_q <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q, err: 1'b0};

endmodule

`default_nettype wire

//--- rtl/sim_ctrl.sv
// Simulation control with character output strobe and sticky halt flag

`timescale 1ns/100ps
`default_nettype none

`include "simple_system_defines.svh"

module sim_ctrl (
  input  wire                         clk_i,
  input  wire                         rst_i,

  input  simple_system_pkg::bus_req_t req_i,
  output simple_system_pkg::bus_rsp_t rsp_o,

  output logic                        char_valid_o,
  output logic [7:0]                  char_o,
  output logic                        halt_o
);

  simple_system_pkg::addr_t offset;
  logic                     wr_out;
  logic                     wr_halt;
  logic                     rvalid_q;

  assign offset = req_i.addr & ~`SIM_CTRL_MASK;

  // Character only counts when the low byte lane is written
  assign wr_out  = req_i.req && req_i.we && (offset == `SIM_CTRL_OUT) && req_i.be[0];
  assign wr_halt = req_i.req && req_i.we && (offset == `SIM_CTRL_HALT);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      char_valid_o <= 1'b0;
      halt_o       <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      char_valid_o <= wr_out;
      rvalid_q     <= req_i.req;
      // Stays set until reset
      if (wr_halt) begin
        halt_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_out) begin
      char_o <= req_i.wdata[7:0];
    end
  end

  // Reads give zero, no error
  assign rsp_o = '{rvalid: rvalid_q, rdata: '0, err: 1'b0};

endmodule

`default_nettype wire

//--- rtl/timer.sv
// Machine timer with 64-bit mtime, mtimecmp and a registered interrupt

`timescale 1ns/100ps
`default_nettype none

`include "simple_system_defines.svh"

module timer (
  input  wire                         clk_i,
  input  wire                         rst_i,

  input  simple_system_pkg::bus_req_t req_i,
  output simple_system_pkg::bus_rsp_t rsp_o,

  output logic                        irq_o
);

  simple_system_pkg::timer_t mtime_q;
  simple_system_pkg::timer_t mtime_d;
  simple_system_pkg::timer_t mtimecmp_q;
  simple_system_pkg::timer_t mtimecmp_d;
  simple_system_pkg::addr_t  offset;
  simple_system_pkg::data_t  rdata_d;
  simple_system_pkg::data_t  rdata_q;
  logic                      rvalid_q;
  logic                      err_q;
  logic                      offset_ok;
  logic                      wr;

  // Enabled bytes of wdata replace the old word
  function automatic simple_system_pkg::data_t be_merge(
    input simple_system_pkg::data_t old_val,
    input simple_system_pkg::data_t new_val,
    input simple_system_pkg::be_t   be
  );
    simple_system_pkg::data_t res;
    res = old_val;
    for (int i = 0; i < $bits(simple_system_pkg::be_t); i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign offset = req_i.addr & ~`TIMER_MASK;
  assign wr     = req_i.req && req_i.we;

  // Register decode for both write and read
  always_comb begin
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    offset_ok  = 1'b1;
    rdata_d    = '0;
    case (offset)
      `MTIME_LO: begin
        rdata_d = mtime_q[31:0];
        if (wr) begin
          mtime_d = {mtime_q[63:32], be_merge(mtime_q[31:0], req_i.wdata, req_i.be)};
        end
      end
      `MTIME_HI: begin
        rdata_d = mtime_q[63:32];
        if (wr) begin
          mtime_d = {be_merge(mtime_q[63:32], req_i.wdata, req_i.be), mtime_q[31:0]};
        end
      end
      `MTIMECMP_LO: begin
        rdata_d = mtimecmp_q[31:0];
        if (wr) begin
          mtimecmp_d[31:0] = be_merge(mtimecmp_q[31:0], req_i.wdata, req_i.be);
        end
      end
      `MTIMECMP_HI: begin
        rdata_d = mtimecmp_q[63:32];
        if (wr) begin
          mtimecmp_d[63:32] = be_merge(mtimecmp_q[63:32], req_i.wdata, req_i.be);
        end
      end
      default: begin
        offset_ok = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_o      <= 1'b0;
      rvalid_q   <= 1'b0;
      err_q      <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      irq_o      <= (mtime_q >= mtimecmp_q);
      rvalid_q   <= req_i.req;
      err_q      <= req_i.req && !offset_ok;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= rdata_d;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q, err: err_q};

endmodule

`default_nettype wire

//--- rtl/simple_system_top.sv
// Simple system top level joining the host port, bus and three devices

`timescale 1ns/100ps
`default_nettype none

`include "simple_system_defines.svh"

module simple_system_top (
  input  wire                         clk_i,
  input  wire                         rst_i,

  input  simple_system_pkg::bus_req_t host_req_i,
  output logic                        host_gnt_o,
  output simple_system_pkg::bus_rsp_t host_rsp_o,

  output logic                        char_valid_o,
  output logic [7:0]                  char_o,
  output logic                        halt_o,
  output logic                        timer_irq_o
);

  // Per-device request and response
  simple_system_pkg::bus_req_t ram_req;
  simple_system_pkg::bus_req_t ctrl_req;
  simple_system_pkg::bus_req_t timer_req;
  simple_system_pkg::bus_rsp_t ram_rsp;
  simple_system_pkg::bus_rsp_t ctrl_rsp;
  simple_system_pkg::bus_rsp_t timer_rsp;

  bus_xbar u_bus_xbar (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .host_req_i  (host_req_i),
    .host_gnt_o  (host_gnt_o),
    .host_rsp_o  (host_rsp_o),
    .ram_req_o   (ram_req),
    .ctrl_req_o  (ctrl_req),
    .timer_req_o (timer_req),
    .ram_rsp_i   (ram_rsp),
    .ctrl_rsp_i  (ctrl_rsp),
    .timer_rsp_i (timer_rsp)
  );

  // Data SRAM
  ram_1p #(
    .Depth (`RAM_WORDS)
  ) u_ram (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (ram_req),
    .rsp_o (ram_rsp)
  );

  sim_ctrl u_sim_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (ctrl_req),
    .rsp_o        (ctrl_rsp),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

  timer u_timer (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (timer_req),
    .rsp_o (timer_rsp),
    .irq_o (timer_irq_o)
  );

endmodule

`default_nettype wire

//--- tests/tb_simple_system.sv
// Testbench for the simple system with random host traffic against a reference model

`timescale 1ns/100ps
`default_nettype none

`include "simple_system_defines.svh"

module tb_simple_system;

  // Words of the RAM used for random traffic
  localparam int unsigned RamWin = 32;

  typedef struct {
    logic                     chk_data;
    simple_system_pkg::data_t data;
    logic                     err;
  } exp_rsp_t;

  logic                        clk = 1'b0;
  logic                        rst;
  simple_system_pkg::bus_req_t host_req;
  logic                        host_gnt;
  simple_system_pkg::bus_rsp_t host_rsp;
  logic                        char_valid;
  logic [7:0]                  char_out;
  logic                        halt;
  logic                        timer_irq;

  // Reference model state
  simple_system_pkg::data_t    ram_model [simple_system_pkg::addr_t];
  simple_system_pkg::timer_t   cmp_model;
  exp_rsp_t                    exp_q [$];
  simple_system_pkg::bus_rsp_t last_rsp;
  logic                        char_pend;
  logic [7:0]                  char_exp;
  logic                        halt_model;
  int unsigned                 mismatches;
  int unsigned                 timeouts;

  simple_system_top i_simple_system_top (
    .clk_i        (clk),
    .rst_i        (rst),
    .host_req_i   (host_req),
    .host_gnt_o   (host_gnt),
    .host_rsp_o   (host_rsp),
    .char_valid_o (char_valid),
    .char_o       (char_out),
    .halt_o       (halt),
    .timer_irq_o  (timer_irq)
  );

  always #10 clk = ~clk;

  function automatic simple_system_pkg::dev_sel_t region_of(input simple_system_pkg::addr_t a);
    if ((a & `RAM_MASK) == `RAM_BASE) begin
      return simple_system_pkg::DEV_RAM;
    end else if ((a & `SIM_CTRL_MASK) == `SIM_CTRL_BASE) begin
      return simple_system_pkg::DEV_SIM_CTRL;
    end else if ((a & `TIMER_MASK) == `TIMER_BASE) begin
      return simple_system_pkg::DEV_TIMER;
    end
    return simple_system_pkg::DEV_NONE;
  endfunction

  function automatic simple_system_pkg::data_t merge_bytes(input simple_system_pkg::data_t old_w,
                                                           input simple_system_pkg::data_t new_w,
                                                           input simple_system_pkg::be_t   be);
    simple_system_pkg::data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic simple_system_pkg::bus_req_t make_req(input logic                     we,
                                                           input simple_system_pkg::be_t   be,
                                                           input simple_system_pkg::addr_t addr,
                                                           input simple_system_pkg::data_t wdata);
    simple_system_pkg::bus_req_t r;
    r       = '0;
    r.req   = 1'b1;
    r.we    = we;
    r.be    = be;
    r.addr  = addr;
    r.wdata = wdata;
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      mismatches++;
    end
  endtask

  // Expected response of one granted access and the matching model updates
  task automatic model_access(input simple_system_pkg::bus_req_t r);
    exp_rsp_t                 e;
    simple_system_pkg::addr_t off;
    simple_system_pkg::addr_t widx;
    e.chk_data = 1'b0;
    e.data     = '0;
    e.err      = 1'b0;
    case (region_of(r.addr))
      simple_system_pkg::DEV_RAM: begin
        widx = (r.addr & ~`RAM_MASK) >> 2;
        if (ram_model.exists(widx)) begin
          e.chk_data = !r.we;
          e.data     = ram_model[widx];
          if (r.we) begin
            ram_model[widx] = merge_bytes(ram_model[widx], r.wdata, r.be);
          end
        end else if (r.we) begin
          ram_model[widx] = merge_bytes('x, r.wdata, r.be);
        end
      end
      simple_system_pkg::DEV_SIM_CTRL: begin
        off        = r.addr & ~`SIM_CTRL_MASK;
        e.chk_data = !r.we;
        if (r.we && off == `SIM_CTRL_OUT && r.be[0]) begin
          char_pend = 1'b1;
          char_exp  = r.wdata[7:0];
        end
        if (r.we && off == `SIM_CTRL_HALT) begin
          halt_model = 1'b1;
        end
      end
      simple_system_pkg::DEV_TIMER: begin
        off = r.addr & ~`TIMER_MASK;
        case (off)
          // mtime runs freely and is checked against bounds
          `MTIME_LO, `MTIME_HI: begin
          end
          `MTIMECMP_LO: begin
            e.chk_data = !r.we;
            e.data     = cmp_model[31:0];
            if (r.we) begin
              cmp_model[31:0] = merge_bytes(cmp_model[31:0], r.wdata, r.be);
            end
          end
          `MTIMECMP_HI: begin
            e.chk_data = !r.we;
            e.data     = cmp_model[63:32];
            if (r.we) begin
              cmp_model[63:32] = merge_bytes(cmp_model[63:32], r.wdata, r.be);
            end
          end
          default: begin
            e.err = 1'b1;
          end
        endcase
      end
      default: begin
        e.chk_data = 1'b1;
        e.err      = 1'b1;
      end
    endcase
    exp_q.push_back(e);
  endtask

  // One bus cycle driven after the edge and checked mid-cycle
  task automatic step(input simple_system_pkg::bus_req_t nxt);
    exp_rsp_t e;
    @(posedge clk);
    #2;
    host_req = nxt;
    #8;
    check_value("host_gnt_o", nxt.req, host_gnt);
    last_rsp = host_rsp;
    if (exp_q.size() > 0) begin
      e = exp_q.pop_front();
      check_value("host_rsp_o.rvalid", 1'b1, host_rsp.rvalid);
      check_value("host_rsp_o.err", e.err, host_rsp.err);
      if (e.chk_data) begin
        check_value("host_rsp_o.rdata", e.data, host_rsp.rdata);
      end
    end else begin
      check_value("host_rsp_o.rvalid", 1'b0, host_rsp.rvalid);
    end
    check_value("char_valid_o", char_pend, char_valid);
    if (char_pend) begin
      check_value("char_o", char_exp, char_out);
    end
    check_value("halt_o", halt_model, halt);
    char_pend = 1'b0;
    if (nxt.req) begin
      model_access(nxt);
    end
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) step('0);
  endtask

  task automatic write_word(input simple_system_pkg::addr_t a, input simple_system_pkg::data_t d);
    step(make_req(1'b1, 4'hF, a, d));
  endtask

  // Read and hand back the data of its response
  task automatic read_word(input simple_system_pkg::addr_t a, output simple_system_pkg::data_t d);
    step(make_req(1'b0, 4'hF, a, '0));
    step('0);
    d = last_rsp.rdata;
  endtask

  task automatic wait_irq(input logic level);
    int unsigned cnt;
    cnt = 0;
    while (timer_irq !== level && cnt < 5) begin
      step('0);
      cnt++;
    end
    assert (timer_irq === level) else begin
      $display("Timer interrupt did not go to %0b within 5 cycles at %0t", level, $time);
      timeouts++;
    end
  endtask

  initial begin
    simple_system_pkg::addr_t a;
    simple_system_pkg::data_t v1;
    simple_system_pkg::data_t v2;
    simple_system_pkg::data_t known;
    int unsigned              n;
    void'($urandom(32'hdce8a1a6));
    host_req   = '0;
    rst        = 1'b1;
    mismatches = 0;
    timeouts   = 0;
    char_pend  = 1'b0;
    char_exp   = '0;
    halt_model = 1'b0;
    cmp_model  = '1;
    last_rsp   = '0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    idle(2);
    check_value("timer_irq_o", 1'b0, timer_irq);

    // RAM window filled with an address pattern before random traffic
    for (int i = 0; i < RamWin; i++) begin
      a = `RAM_BASE + 4 * i;
      write_word(a, a ^ 32'h5a5a_a5a5);
    end
    for (int i = 0; i < 400; i++) begin
      a = `RAM_BASE + 4 * ($urandom % RamWin);
      step(make_req(1'($urandom % 2), simple_system_pkg::be_t'($urandom), a, $urandom));
      if ($urandom % 8 == 0) begin
        idle(1);
      end
    end
    idle(1);

    // Unmapped accesses leave the RAM intact
    for (int i = 0; i < 50; i++) begin
      do begin
        a = $urandom;
      end while (region_of(a) != simple_system_pkg::DEV_NONE);
      step(make_req(1'($urandom % 2), simple_system_pkg::be_t'($urandom), a, $urandom));
    end
    for (int i = 0; i < RamWin; i++) begin
      step(make_req(1'b0, 4'hF, `RAM_BASE + 4 * i, '0));
    end
    idle(1);

    // Character output, halt flag and sim control reads
    for (int i = 0; i < 20; i++) begin
      step(make_req(1'b1, simple_system_pkg::be_t'($urandom) | 4'b0001,
                    `SIM_CTRL_BASE + `SIM_CTRL_OUT, $urandom));
    end
    step(make_req(1'b1, 4'b1110, `SIM_CTRL_BASE + `SIM_CTRL_OUT, $urandom));
    step(make_req(1'b0, 4'hF, `SIM_CTRL_BASE + `SIM_CTRL_OUT, '0));
    step(make_req(1'b0, 4'hF, `SIM_CTRL_BASE + `SIM_CTRL_HALT, '0));
    write_word(`SIM_CTRL_BASE + `SIM_CTRL_HALT, 32'h1);
    for (int i = 0; i < 10; i++) begin
      step(make_req(1'b0, 4'hF, `RAM_BASE + 4 * ($urandom % RamWin), '0));
    end
    idle(1);
    check_value("halt_o", 1'b1, halt);

    // Timer register access
    write_word(`TIMER_BASE + `MTIMECMP_LO, $urandom);
    write_word(`TIMER_BASE + `MTIMECMP_HI, $urandom);
    read_word(`TIMER_BASE + `MTIMECMP_LO, v1);
    read_word(`TIMER_BASE + `MTIMECMP_HI, v1);
    read_word(`TIMER_BASE + `MTIME_LO, v1);
    read_word(`TIMER_BASE + `MTIME_LO, v2);
    assert (v2 > v1) else begin
      $display("Mismatch at %0t: mtime_lo expected above %0h, got %0h", $time, v1, v2);
      mismatches++;
    end
    known = $urandom & 32'h0FFF_FFFF;
    write_word(`TIMER_BASE + `MTIME_HI, 32'h0);
    write_word(`TIMER_BASE + `MTIME_LO, known);
    n = 3 + $urandom % 10;
    idle(n);
    read_word(`TIMER_BASE + `MTIME_LO, v1);
    assert (v1 >= known && v1 <= known + n + 2) else begin
      $display("Mismatch at %0t: mtime_lo expected %0h to %0h, got %0h",
               $time, known, known + n + 2, v1);
      mismatches++;
    end
    read_word(`TIMER_BASE + 32'h10, v1);
    write_word(`TIMER_BASE + 32'h3FC, $urandom);

    // Interrupt against mtimecmp
    write_word(`TIMER_BASE + `MTIMECMP_HI, 32'h8000_0000);
    write_word(`TIMER_BASE + `MTIMECMP_LO, 32'h0);
    idle(3);
    for (int i = 0; i < 10; i++) begin
      step('0);
      check_value("timer_irq_o", 1'b0, timer_irq);
    end
    write_word(`TIMER_BASE + `MTIMECMP_LO, 32'h0);
    write_word(`TIMER_BASE + `MTIMECMP_HI, 32'h0);
    wait_irq(1'b1);
    write_word(`TIMER_BASE + `MTIMECMP_HI, 32'hFFFF_FFFF);
    write_word(`TIMER_BASE + `MTIMECMP_LO, 32'hFFFF_FFFF);
    wait_irq(1'b0);
    idle(2);

    $display("Mismatches: %0d, timeouts: %0d", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- simple_system.f
+incdir+rtl
rtl/simple_system_pkg.sv
rtl/bus_xbar.sv
rtl/ram_1p.sv
rtl/sim_ctrl.sv
rtl/timer.sv
rtl/simple_system_top.sv
tests/tb_simple_system.sv

//--- Bender.yml
package:
  name: simple_system

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/simple_system_pkg.sv
      - rtl/bus_xbar.sv
      - rtl/ram_1p.sv
      - rtl/sim_ctrl.sv
      - rtl/timer.sv
      - rtl/simple_system_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tests/tb_simple_system.sv
